/* common/txPkg.sv */
`default_nettype none

package txPkg;

	////////////////////////////////////////////////////////////
	// Shot types
	////////////////////////////////////////////////////////////

	typedef logic [7:0] lineNumT;    // Lines 0 to 255
	typedef logic [1:0] focusT;      // Four focus zones
	typedef logic [5:0] emitWidthT;  // Cycles per pulse phase
	typedef logic [7:0] timerT;      // Cycles since shot start
	typedef logic [3:0] rotationT;   // Aperture shift in channels
	typedef logic [15:0] chanVecT;   // One bit per channel

	typedef struct packed {
		logic mute;                  // Channel silent for the shot
		logic [6:0] delay;           // Fire delay in cycles
	} channelDelayS;

	typedef struct packed {
		emitWidthT emitWidth;
		rotationT rotation;
	} shotSetupS;

	typedef struct packed {
		logic firing;
		timerT timer;
	} fireCtrlS;

	typedef enum logic [1:0] {
		Idle,
		Firing,
		Done
	} fireStateT;

	////////////////////////////////////////////////////////////
	// Focus tables
	////////////////////////////////////////////////////////////

	localparam int refChannel = 7;   // Channel that triggers sampling

	// One phase width per focus zone, deeper zones run slower
	localparam emitWidthT emitWidths [4] = '{6'd6, 6'd7, 6'd8, 6'd8};

	// Channel 0 sits in the leftmost byte of each row
	// Index 0 is an even line, index 1 an odd line
	// Zone 3 reuses the zone 2 row
	localparam channelDelayS [0:15] delayProfiles [3][2] = '{
		'{
			128'h0004070A0C0D0E0E0E0D0C0A07040080,  // Near zone
			128'h800004070A0C0D0E0E0E0D0C0A070400
		},
		'{
			128'h00020305060707070707060503020080,  // Mid zone
			128'h80000203050607070707070605030200
		},
		'{
			128'h00010203040405050504040302010080,  // Far zones
			128'h80000102030404050505040403020100
		}
	};

endpackage

`default_nettype wire

/* hw/fireTimer.sv */
`timescale 1ns/10ps
`default_nettype none

module fireTimer (
	input wire logic Transmit_CLK,
	input wire logic Pr_Gate,
	input wire logic firing,
	output txPkg::timerT timer
);

	logic atMax;

	assign atMax = (timer == '1);

	// Zero on the first firing cycle, holds at full scale
	always_ff @(posedge Transmit_CLK or negedge Pr_Gate) begin
		if (!Pr_Gate) begin
			timer <= '0;
		end else if (!firing) begin
			timer <= '0;
		end else if (!atMax) begin
			timer <= timer + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/fireSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module fireSequencer #(
	parameter int FireSpan = 160,
	parameter int SampleWidth = 5
) (
	input wire logic Transmit_CLK,
	input wire logic Pr_Gate,
	input wire logic rxGate,
	input wire txPkg::timerT timer,
	input wire txPkg::channelDelayS refDelay,
	output logic startShot,
	output logic firing,
	output logic sampleGate
);

	txPkg::fireStateT state;
	logic lastCycle;
	logic inWindow;
	logic windowHit;                  // First stage, matches pulser register
	logic [8:0] winEnd;

	assign startShot = (state == txPkg::Idle) && rxGate;  // Table latches on this edge
	assign firing = (state == txPkg::Firing);
	assign lastCycle = (timer == txPkg::timerT'(FireSpan - 1));

	// Sampling window follows the reference channel's P rise
	assign winEnd = {2'b00, refDelay.delay} + 9'(SampleWidth);
	assign inWindow = firing && !refDelay.mute
		&& (timer >= {1'b0, refDelay.delay})
		&& ({1'b0, timer} < winEnd);

	always_ff @(posedge Transmit_CLK or negedge Pr_Gate) begin
		if (!Pr_Gate) begin
			state <= txPkg::Idle;
			windowHit <= 1'b0;
			sampleGate <= 1'b0;
		end else begin
			windowHit <= inWindow;
			sampleGate <= windowHit;  // Second stage, matches rotator register
			case (state)
				txPkg::Idle: if (startShot) state <= txPkg::Firing;
				txPkg::Firing: if (lastCycle) state <= txPkg::Done;
				txPkg::Done: if (!rxGate) state <= txPkg::Idle;  // Wait for request drop
				default: state <= txPkg::Idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* beamformer/delayProfileTable.sv */
`timescale 1ns/10ps
`default_nettype none

module delayProfileTable (
	input wire logic Transmit_CLK,
	input wire logic Pr_Gate,
	input wire logic startShot,
	input wire txPkg::lineNumT lineNum,
	input wire txPkg::focusT focusNum,
	output txPkg::shotSetupS setup,
	output txPkg::channelDelayS [0:15] delays
);

	logic [1:0] tableSel;
	logic parity;
	txPkg::rotationT rotation;

	////////////////////////////////////////////////////////////
	// Profile select
	////////////////////////////////////////////////////////////

	assign tableSel = (focusNum == 2'd3) ? 2'd2 : focusNum;  // Zones 2 and 3 share
	assign parity = lineNum[0];                              // Odd lines mute channel 0

	// Pairs of lines share one aperture position
	assign rotation = lineNum[4:1] + 4'd8;

	////////////////////////////////////////////////////////////
	// Shot latch
	////////////////////////////////////////////////////////////

	always_ff @(posedge Transmit_CLK or negedge Pr_Gate) begin
		if (!Pr_Gate) begin
			setup <= '0;
			delays <= '0;
		end else if (startShot) begin
			setup.emitWidth <= txPkg::emitWidths[focusNum];
			setup.rotation <= rotation;
			delays <= txPkg::delayProfiles[tableSel][parity];
		end
	end

endmodule

`default_nettype wire

/* beamformer/channelPulser.sv */
`timescale 1ns/10ps
`default_nettype none

module channelPulser (
	input wire logic Transmit_CLK,
	input wire logic Pr_Gate,
	input wire txPkg::fireCtrlS ctrl,
	input wire txPkg::channelDelayS chanDelay,
	input wire txPkg::emitWidthT emitWidth,
	output logic txP,
	output logic txN
);

	logic [8:0] now;
	logic [8:0] pStart;
	logic [8:0] nStart;
	logic [8:0] nEnd;
	logic enable;
	logic pHit;
	logic nHit;

	// Nine bits so delay plus two phases cannot wrap
	assign now = {1'b0, ctrl.timer};
	assign pStart = {2'b00, chanDelay.delay};
	assign nStart = pStart + {3'b000, emitWidth};  // N follows P directly
	assign nEnd = nStart + {3'b000, emitWidth};

	assign enable = ctrl.firing && !chanDelay.mute;
	assign pHit = enable && (now >= pStart) && (now < nStart);
	assign nHit = enable && (now >= nStart) && (now < nEnd);

	always_ff @(posedge Transmit_CLK or negedge Pr_Gate) begin
		if (!Pr_Gate) begin
			txP <= 1'b0;
			txN <= 1'b0;
		end else begin
			txP <= pHit;
			txN <= nHit;
		end
	end

endmodule

`default_nettype wire

/* beamformer/apertureRotator.sv */
`timescale 1ns/10ps
`default_nettype none

module apertureRotator #(
	parameter int ChannelCount = 16
) (
	input wire logic Transmit_CLK,
	input wire logic Pr_Gate,
	input wire txPkg::rotationT rotation,
	input wire txPkg::chanVecT txP,
	input wire txPkg::chanVecT txN,
	output txPkg::chanVecT p,
	output txPkg::chanVecT n
);

	logic [2*ChannelCount-1:0] pWide;
	logic [2*ChannelCount-1:0] nWide;

	// Upper half of the doubled vector is a left rotation
	// so output bit j carries channel j minus rotation
	assign pWide = {txP, txP} << rotation;
	assign nWide = {txN, txN} << rotation;

	always_ff @(posedge Transmit_CLK or negedge Pr_Gate) begin
		if (!Pr_Gate) begin
			p <= '0;
			n <= '0;
		end else begin
			p <= pWide[2*ChannelCount-1 -: ChannelCount];
			n <= nWide[2*ChannelCount-1 -: ChannelCount];
		end
	end

endmodule

`default_nettype wire

/* hw/transmit.sv */
`timescale 1ns/10ps
`default_nettype none

module transmit #(
	parameter int ChannelCount = 16,
	parameter int FireSpan = 160,
	parameter int SampleWidth = 5
) (
	input wire logic Transmit_CLK,
	input wire logic Pr_Gate,
	input wire logic rxGate,
	input wire txPkg::lineNumT lineNum,
	input wire txPkg::focusT focusNum,
	output wire logic sampleGate,
	output wire txPkg::chanVecT p,
	output wire txPkg::chanVecT n
);

	wire logic startShot;
	wire logic firing;
	wire txPkg::timerT timer;
	wire txPkg::fireCtrlS fireCtrl;
	wire txPkg::shotSetupS setup;
	wire txPkg::channelDelayS [0:15] delays;
	wire txPkg::chanVecT txP;         // Unrotated channel order
	wire txPkg::chanVecT txN;

	assign fireCtrl = '{firing: firing, timer: timer};

	fireSequencer #(
		.FireSpan(FireSpan),
		.SampleWidth(SampleWidth)
	) uSequencer (
		.Transmit_CLK(Transmit_CLK),
		.Pr_Gate(Pr_Gate),
		.rxGate(rxGate),
		.timer(timer),
		.refDelay(delays[txPkg::refChannel]),
		.startShot(startShot),
		.firing(firing),
		.sampleGate(sampleGate)
	);

	fireTimer uTimer (
		.Transmit_CLK(Transmit_CLK),
		.Pr_Gate(Pr_Gate),
		.firing(firing),
		.timer(timer)
	);

	delayProfileTable uProfile (
		.Transmit_CLK(Transmit_CLK),
		.Pr_Gate(Pr_Gate),
		.startShot(startShot),
		.lineNum(lineNum),
		.focusNum(focusNum),
		.setup(setup),
		.delays(delays)
	);

	////////////////////////////////////////////////////////////
	// Per-channel pulsers
	////////////////////////////////////////////////////////////

	for (genvar ch = 0; ch < ChannelCount; ch++) begin : gPulser
		channelPulser uPulser (
			.Transmit_CLK(Transmit_CLK),
			.Pr_Gate(Pr_Gate),
			.ctrl(fireCtrl),
			.chanDelay(delays[ch]),
			.emitWidth(setup.emitWidth),
			.txP(txP[ch]),
			.txN(txN[ch])
		);
	end

	apertureRotator #(
		.ChannelCount(ChannelCount)
	) uRotator (
		.Transmit_CLK(Transmit_CLK),
		.Pr_Gate(Pr_Gate),
		.rotation(setup.rotation),
		.txP(txP),
		.txN(txN),
		.p(p),
		.n(n)
	);

endmodule

`default_nettype wire

/* verification/transmitTb.sv */
`timescale 1ns/10ps
`default_nettype none

module transmitTb;

	localparam int ChannelCount = 16;
	localparam int FireSpan = 160;
	localparam int SampleWidth = 5;
	localparam int ClkPeriod = 40;
	localparam int RowCount = 16;
	localparam int RowBytes = 19;                      // Focus, line, 16 delays, width
	localparam int RecordCycles = FireSpan + 4;
	localparam int HoldCycles = 16;
	localparam int ShotLatency = 3;                    // Request edge to timer zero on the pins
	localparam int WatchdogCycles = RowCount * (FireSpan + 40);

	logic Transmit_CLK;
	logic Pr_Gate;
	logic rxGate;
	txPkg::lineNumT lineNum;
	txPkg::focusT focusNum;
	logic sampleGate;
	txPkg::chanVecT p;
	txPkg::chanVecT n;

	logic [7:0] stimMem [RowCount * RowBytes];
	txPkg::chanVecT pHist [RecordCycles];             // Pin samples per cycle
	txPkg::chanVecT nHist [RecordCycles];
	logic sgHist [RecordCycles];
	logic [31:0] rngState = 32'h494e_fdb0;

	transmit #(
		.ChannelCount(ChannelCount),
		.FireSpan(FireSpan),
		.SampleWidth(SampleWidth)
	) uut (
		.Transmit_CLK(Transmit_CLK),
		.Pr_Gate(Pr_Gate),
		.rxGate(rxGate),
		.lineNum(lineNum),
		.focusNum(focusNum),
		.sampleGate(sampleGate),
		.p(p),
		.n(n)
	);

	initial begin
		Transmit_CLK = 1'b0;
		forever #(ClkPeriod / 2) Transmit_CLK = ~Transmit_CLK;
	end

	initial begin
		#(WatchdogCycles * ClkPeriod);
		$display("Watchdog expired after %0d cycles without the run completing", WatchdogCycles);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation timed out");
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic checkStimulus();
		int base;
		for (int r = 0; r < RowCount; r++) begin
			base = r * RowBytes;
			if ($isunknown(stimMem[base + 18]) || stimMem[base] > 8'd3
				|| stimMem[base + 18] == 8'd0) begin
				$display("Row %0d of the stimulus file is missing or malformed", r);
				$display("ERRORS FOUND");
				$fatal(1, "Bad stimulus file");
			end
		end
	endtask

	// Outputs must stay low on every sample
	task automatic idleCycles(input int count, input string phase);
		for (int c = 0; c < count; c++) begin
			@(negedge Transmit_CLK);
			compareValue($sformatf("p %s", phase), 32'(p), 32'd0);
			compareValue($sformatf("n %s", phase), 32'(n), 32'd0);
			compareValue($sformatf("sampleGate %s", phase), 32'(sampleGate), 32'd0);
		end
	endtask

	task automatic runShot(input int r);
		int base;
		base = r * RowBytes;
		@(posedge Transmit_CLK);
		focusNum <= stimMem[base][1:0];
		lineNum <= stimMem[base + 1];
		rxGate <= 1'b1;
		for (int c = 0; c < RecordCycles; c++) begin
			@(negedge Transmit_CLK);                       // Sampled mid-cycle
			pHist[c] = p;
			nHist[c] = n;
			sgHist[c] = sampleGate;
		end
	endtask

	task automatic checkShot(input int r);
		int base;
		int rot;
		int width;
		int refStart;
		int d;
		int ch;
		logic [7:0] entry;
		txPkg::chanVecT expP;
		txPkg::chanVecT expN;
		logic expS;
		base = r * RowBytes;
		rot = (int'(stimMem[base + 1][4:1]) + 8) % ChannelCount;  // Line pairs share a position
		width = int'(stimMem[base + 18]);
		refStart = int'(stimMem[base + 2 + txPkg::refChannel][6:0]) + ShotLatency;
		for (int c = 0; c < RecordCycles; c++) begin
			expP = '0;
			expN = '0;
			for (int j = 0; j < ChannelCount; j++) begin
				ch = (j - rot + ChannelCount) % ChannelCount;
				entry = stimMem[base + 2 + ch];
				d = int'(entry[6:0]) + ShotLatency;
				if (!entry[7] && c >= d && c < d + width) expP[j] = 1'b1;
				if (!entry[7] && c >= d + width && c < d + 2 * width) expN[j] = 1'b1;
			end
			expS = (c >= refStart) && (c < refStart + SampleWidth);
			compareValue($sformatf("p row %0d cycle %0d", r, c), 32'(pHist[c]), 32'(expP));
			compareValue($sformatf("n row %0d cycle %0d", r, c), 32'(nHist[c]), 32'(expN));
			compareValue($sformatf("sampleGate row %0d cycle %0d", r, c),
				32'(sgHist[c]), 32'(expS));
		end
	endtask

	task automatic releaseRequest();
		@(posedge Transmit_CLK);
		rxGate <= 1'b0;
		@(negedge Transmit_CLK);
		while (uut.uSequencer.state != txPkg::Idle) begin
			@(negedge Transmit_CLK);                       // Watchdog bounds this wait
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int gap;
		Pr_Gate <= 1'b0;
		rxGate <= 1'b0;
		lineNum <= '0;
		focusNum <= '0;
		$readmemh("verification/txInput.mem", stimMem);
		checkStimulus();
		repeat (5) @(posedge Transmit_CLK);
		Pr_Gate <= 1'b1;
		idleCycles(4, "after reset");
		for (int r = 0; r < RowCount; r++) begin
			runShot(r);
			checkShot(r);
			idleCycles(HoldCycles, "while request held");  // No second burst
			releaseRequest();
			rngState = xorshift32(rngState);
			gap = 1 + int'(rngState[2:0]);
			idleCycles(gap, "between shots");
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/txInput.mem */
// focus line delay0 .. delay15 width, one shot per row, all hex bytes
// delay byte: bit 7 mutes the channel, bits 6:0 give the delay in cycles
00 00 00 04 07 0A 0C 0D 0E 0E 0E 0D 0C 0A 07 04 00 80 06
00 01 80 00 04 07 0A 0C 0D 0E 0E 0E 0D 0C 0A 07 04 00 06
01 02 00 02 03 05 06 07 07 07 07 07 06 05 03 02 00 80 07
01 03 80 00 02 03 05 06 07 07 07 07 07 06 05 03 02 00 07
02 10 00 01 02 03 04 04 05 05 05 04 04 03 02 01 00 80 08
02 11 80 00 01 02 03 04 04 05 05 05 04 04 03 02 01 00 08
03 1E 00 01 02 03 04 04 05 05 05 04 04 03 02 01 00 80 08
03 1F 80 00 01 02 03 04 04 05 05 05 04 04 03 02 01 00 08
00 2A 00 04 07 0A 0C 0D 0E 0E 0E 0D 0C 0A 07 04 00 80 06
01 55 80 00 02 03 05 06 07 07 07 07 07 06 05 03 02 00 07
02 7C 00 01 02 03 04 04 05 05 05 04 04 03 02 01 00 80 08
03 93 80 00 01 02 03 04 04 05 05 05 04 04 03 02 01 00 08
00 C7 80 00 04 07 0A 0C 0D 0E 0E 0E 0D 0C 0A 07 04 00 06
01 E0 00 02 03 05 06 07 07 07 07 07 06 05 03 02 00 80 07
02 FF 80 00 01 02 03 04 04 05 05 05 04 04 03 02 01 00 08
03 08 00 01 02 03 04 04 05 05 05 04 04 03 02 01 00 80 08

/* flist.f */
common/txPkg.sv
hw/fireTimer.sv
hw/fireSequencer.sv
beamformer/delayProfileTable.sv
beamformer/channelPulser.sv
beamformer/apertureRotator.sv
hw/transmit.sv
verification/transmitTb.sv

/* Makefile */
TOP = transmitTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/10ps -j 0 \
		--top-module $(TOP) -f flist.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -Wall \
		--top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir
